// File: testbench/irq_unit_stimulus.txt
// irq mie mstatus_mie valid err instr pipe_idle debug_req | ack id mip sleep
// Inputs of one cycle, then the outputs expected after its rising edge, all hex
FFFFFFFF 00000000 0 0 0 00000000 0 0  0 00 FFFF0888 0
0000F777 00000000 0 0 0 00000000 0 0  0 00 00000000 0
00000888 00000000 0 0 0 00000000 0 0  0 00 00000888 0
00000888 00000888 1 0 0 00000000 0 0  1 0B 00000888 0
00000888 00000888 1 0 0 00000000 0 0  0 00 00000888 0
00000088 00000888 1 0 0 00000000 0 0  1 0B 00000088 0
00000088 00000888 1 0 0 00000000 0 0  0 00 00000088 0
00000088 00000888 1 0 0 00000000 0 0  1 03 00000088 0
00010088 FFFF0888 1 0 0 00000000 0 0  0 00 00010088 0
00010088 FFFF0888 1 0 0 00000000 0 0  1 10 00010088 0
80000088 FFFF0888 1 0 0 00000000 0 0  0 00 80000088 0
80000088 FFFF0888 1 0 0 00000000 0 0  1 1F 80000088 0
00000000 FFFF0888 1 0 0 00000000 0 0  0 00 00000000 0
00000000 FFFF0888 1 0 0 00000000 0 0  0 00 00000000 0
00000080 00000008 1 0 0 00000000 0 0  0 00 00000080 0
00000080 00000008 1 0 0 00000000 0 0  0 00 00000080 0
00000080 00000088 1 0 0 00000000 0 0  1 07 00000080 0
00000080 00000088 0 0 0 00000000 0 0  0 00 00000080 0
00000080 00000088 0 0 0 00000000 0 0  0 00 00000080 0
00000080 00000088 1 0 0 00000000 0 0  1 07 00000080 0
00000000 00000000 1 0 0 00000000 0 0  0 00 00000000 0
00000800 00000800 1 0 0 00000000 0 0  0 00 00000800 0
00000800 00000800 1 0 0 00000000 0 0  1 0B 00000800 0
00000000 00000000 0 0 0 00000000 0 0  0 00 00000000 0
00000000 00000000 0 1 1 10500073 1 0  0 00 00000000 0
00000000 00000000 0 1 0 00000073 1 0  0 00 00000000 0
00000000 00000000 0 1 0 10500073 0 0  0 00 00000000 0
00000000 00000000 0 0 0 00000000 0 0  0 00 00000000 0
00000000 00000000 0 0 0 00000000 1 0  0 00 00000000 1
00000000 00000000 0 0 0 00000000 0 0  0 00 00000000 1
00000008 00000008 0 0 0 00000000 1 0  0 00 00000008 1
00000008 00000008 0 0 0 00000000 1 0  0 00 00000008 0
00000000 00000000 0 0 0 00000000 1 0  0 00 00000000 0
00000000 00000000 0 1 0 10500073 1 0  0 00 00000000 0
00000000 00000000 0 0 0 00000000 1 0  0 00 00000000 1
00000000 00000000 0 0 0 00000000 1 1  0 00 00000000 0
00000000 00000000 0 1 0 10500073 1 1  0 00 00000000 0
00000000 00000000 0 0 0 00000000 1 0  0 00 00000000 1
00000000 00000000 0 0 0 00000000 0 1  0 00 00000000 0

// File: filelist.f
+incdir+source
source/irq_pkg.sv
source/irq_arbiter.sv
source/wfi_sleep_ctrl.sv
source/irq_unit.sv
testbench/irq_unit_asserts.sv
testbench/tb_irq_unit.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_irq_unit
RTL_TOP    = irq_unit
FILELIST   = filelist.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, the binary status is hidden by tee
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG) || { echo "Simulation did not pass"; exit 1; }

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_irq_unit.sv
// Testbench for irq_unit, replays per-cycle vectors from the stimulus file and checks outputs
`timescale 1ns/1ps
`include "irq_params.svh"

module tb_irq_unit;

  localparam string StimFile = "testbench/irq_unit_stimulus.txt";

  // One line of the stimulus file
  typedef struct packed {
    logic [`IRQ_NUM-1:0]  irq;
    logic [`IRQ_NUM-1:0]  mie;
    logic                 mstatus_mie;
    logic                 valid;
    logic                 err;
    logic [`INSTR_W-1:0]  instr;
    logic                 pipe_idle;
    logic                 debug_req;
    logic                 exp_ack;
    logic [`IRQ_ID_W-1:0] exp_id;
    logic [`IRQ_NUM-1:0]  exp_mip;
    logic                 exp_sleep;
  } vector_t;

  logic                clk;
  logic                rst_n;
  logic [`IRQ_NUM-1:0] irq;
  irq_pkg::csr_irq_t   csr;
  irq_pkg::wb_retire_t retire;
  logic                pipe_idle;
  logic                debug_req;
  irq_pkg::irq_ack_t   irq_ack;
  logic [`IRQ_NUM-1:0] mip;
  logic                core_sleep;

  vector_t vectors[$];
  logic    vectors_loaded;

  irq_unit irq_unit_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .irq_i        (irq),
    .csr_i        (csr),
    .retire_i     (retire),
    .pipe_idle_i  (pipe_idle),
    .debug_req_i  (debug_req),
    .irq_ack_o    (irq_ack),
    .mip_o        (mip),
    .core_sleep_o (core_sleep)
  );

  // --------------------------------------------------
  // Clock and watchdog
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Budget covers reset plus every vector with margin
  initial begin
    wait (vectors_loaded);
    repeat (vectors.size() + 20) @(posedge clk);
    $display("The stimulus did not finish in time");
    $display("Verification failed");
    $fatal(1, "Watchdog expired");
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic load_vectors();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] col [12];
    vector_t     v;
    fd = $fopen(StimFile, "r");
    if (fd == 0) begin
      $display("The stimulus file %s could not be opened", StimFile);
      $display("Verification failed");
      $fatal(1, "Stimulus file missing");
    end else begin
      while ($fgets(line, fd) > 0) begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                         col[0], col[1], col[2], col[3], col[4], col[5],
                         col[6], col[7], col[8], col[9], col[10], col[11]);
        // Header comments give no match
        if (fields == 12) begin
          v.irq         = col[0];
          v.mie         = col[1];
          v.mstatus_mie = col[2][0];
          v.valid       = col[3][0];
          v.err         = col[4][0];
          v.instr       = col[5];
          v.pipe_idle   = col[6][0];
          v.debug_req   = col[7][0];
          v.exp_ack     = col[8][0];
          v.exp_id      = col[9][`IRQ_ID_W-1:0];
          v.exp_mip     = col[10];
          v.exp_sleep   = col[11][0];
          vectors.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_vector(input vector_t v);
    irq                = v.irq;
    csr.mie            = v.mie;
    csr.mstatus_mie    = v.mstatus_mie;
    retire.valid       = v.valid;
    retire.err         = v.err;
    retire.instr.raw   = v.instr;
    pipe_idle          = v.pipe_idle;
    debug_req          = v.debug_req;
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic check_outputs(input vector_t v);
    check_value("irq_ack_o.ack", 32'(irq_ack.ack), 32'(v.exp_ack));
    // Id only means something with ack
    if (v.exp_ack) begin
      check_value("irq_ack_o.id", 32'(irq_ack.id), 32'(v.exp_id));
    end
    check_value("mip_o", mip, v.exp_mip);
    check_value("core_sleep_o", 32'(core_sleep), 32'(v.exp_sleep));
    // Bound port properties must all have held so far
    check_value("assertion failures",
                irq_unit_inst.irq_unit_asserts_inst.fail_count, 32'd0);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    vectors_loaded = 1'b0;
    rst_n          = 1'b0;
    irq            = '0;
    csr            = '0;
    retire         = '0;
    pipe_idle      = 1'b0;
    debug_req      = 1'b0;
    load_vectors();
    if (vectors.size() == 0) begin
      $display("The stimulus file holds no vectors");
      $display("Verification failed");
      $fatal(1, "Empty stimulus");
    end else begin
      vectors_loaded = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // Drive just after an edge, check after the next one
      foreach (vectors[i]) begin
        apply_vector(vectors[i]);
        @(posedge clk);
        #1;
        check_outputs(vectors[i]);
      end
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: testbench/irq_unit_asserts.sv
// Concurrent checks on the interrupt unit ports, bound into every irq_unit instance
`timescale 1ns/1ps
`include "irq_params.svh"

module irq_unit_asserts (
  input logic                clk_i,
  input logic                rst_ni,
  input irq_pkg::csr_irq_t   csr_i,
  input irq_pkg::irq_ack_t   irq_ack_i,
  input logic [`IRQ_NUM-1:0] mip_i,
  input logic                core_sleep_i,
  input logic                in_wfi_i
);

  localparam logic [`IRQ_NUM-1:0] ValidMask = `IRQ_VALID_MASK;

  // Enables as the arbiter saw them one cycle back
  logic [`IRQ_NUM-1:0] mie_q;
  logic                mstatus_mie_q;

  // Number of failed properties so far
  int unsigned fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q         <= '0;
      mstatus_mie_q <= 1'b0;
    end else begin
      mie_q         <= csr_i.mie;
      mstatus_mie_q <= csr_i.mstatus_mie;
    end
  end

  // --------------------------------------------------
  // Acknowledge
  // --------------------------------------------------
  // Single-cycle strobe
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i.ack |=> !irq_ack_i.ack)
    else begin
      fail_count++;
      $error("ack high on two cycles in a row");
    end

  // Winner is an implemented line with its local enable set
  ack_id_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i.ack |-> (ValidMask[irq_ack_i.id] && mie_q[irq_ack_i.id]))
    else begin
      fail_count++;
      $error("ack id reserved or not enabled");
    end

  // Global enable was on in the cycle that produced the ack
  ack_global_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i.ack |-> mstatus_mie_q)
    else begin
      fail_count++;
      $error("ack without global enable");
    end

  // --------------------------------------------------
  // Pending and sleep
  // --------------------------------------------------
  mip_reserved: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mip_i & ~ValidMask) == '0)
    else begin
      fail_count++;
      $error("reserved bit set in mip");
    end

  sleep_needs_wfi: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_sleep_i |-> in_wfi_i)
    else begin
      fail_count++;
      $error("sleep while WFI state is clear");
    end

endmodule

bind irq_unit irq_unit_asserts irq_unit_asserts_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .csr_i        (csr_i),
  .irq_ack_i    (irq_ack_o),
  .mip_i        (mip_o),
  .core_sleep_i (core_sleep_o),
  .in_wfi_i     (wfi_sleep_ctrl_inst.in_wfi_q)
);

// File: source/irq_unit.sv
// Top level of the machine-mode interrupt and sleep unit, instantiated by the core or testbench
`timescale 1ns/1ps
`include "irq_params.svh"

module irq_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [`IRQ_NUM-1:0]  irq_i,
  input  irq_pkg::csr_irq_t    csr_i,
  input  irq_pkg::wb_retire_t  retire_i,
  input  logic                 pipe_idle_i,
  input  logic                 debug_req_i,
  output irq_pkg::irq_ack_t    irq_ack_o,
  output logic [`IRQ_NUM-1:0]  mip_o,
  output logic                 core_sleep_o
);

  // Enabled pending level from arbiter to sleep control
  logic irq_pending;

  // --------------------------------------------------
  // Arbitration
  // --------------------------------------------------
  irq_arbiter irq_arbiter_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .csr_i         (csr_i),
    .mip_o         (mip_o),
    .irq_pending_o (irq_pending),
    .irq_ack_o     (irq_ack_o)
  );

  // --------------------------------------------------
  // WFI and sleep
  // --------------------------------------------------
  wfi_sleep_ctrl wfi_sleep_ctrl_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .retire_i      (retire_i),
    .irq_pending_i (irq_pending),
    .debug_req_i   (debug_req_i),
    .pipe_idle_i   (pipe_idle_i),
    .core_sleep_o  (core_sleep_o)
  );

endmodule

// File: source/wfi_sleep_ctrl.sv
// WFI retire decode, wait-for-interrupt state and registered core sleep output
`timescale 1ns/1ps
`include "irq_params.svh"

module wfi_sleep_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  irq_pkg::wb_retire_t retire_i,
  input  logic                irq_pending_i,
  input  logic                debug_req_i,
  input  logic                pipe_idle_i,
  output logic                core_sleep_o
);

  irq_pkg::sys_instr_t sys_f;
  logic                enc_match;
  logic                is_wfi;
  logic                wake;
  logic                in_wfi_q;
  logic                sleep_q;

  // --------------------------------------------------
  // Retire decode
  // --------------------------------------------------
  // Field view of the retired word
  assign sys_f = retire_i.instr.sys;

  // All five SYSTEM fields must hold the WFI values
  assign enc_match = (sys_f.funct12 == `FUNCT12_WFI) &&
                     (sys_f.rs1     == `RS1_ZERO)    &&
                     (sys_f.funct3  == `FUNCT3_ZERO) &&
                     (sys_f.rd      == `RD_ZERO)     &&
                     (sys_f.opcode  == `OPC_SYSTEM);

  // A bus error on fetch disqualifies the retire
  assign is_wfi = retire_i.valid & ~retire_i.err & enc_match;

  // Either wake cause, global enable plays no part
  assign wake = irq_pending_i | debug_req_i;

  // --------------------------------------------------
  // WFI state
  // --------------------------------------------------
  // Retire wins over a wake in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_wfi_q <= 1'b0;
    end else if (is_wfi) begin
      in_wfi_q <= 1'b1;
    end else if (wake) begin
      in_wfi_q <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Sleep output
  // --------------------------------------------------
  // Sleep waits for LSU and fetch buffer to drain
  // Wake drops it on the next edge, otherwise hold
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else if (wake) begin
      sleep_q <= 1'b0;
    end else if (in_wfi_q && pipe_idle_i) begin
      sleep_q <= 1'b1;
    end
  end

  assign core_sleep_o = sleep_q;

endmodule

// File: source/irq_arbiter.sv
// Pending register, fixed-priority interrupt arbitration and acknowledge pulse generation
`timescale 1ns/1ps
`include "irq_params.svh"

module irq_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [`IRQ_NUM-1:0]  irq_i,
  input  irq_pkg::csr_irq_t    csr_i,
  output logic [`IRQ_NUM-1:0]  mip_o,
  output logic                 irq_pending_o,
  output irq_pkg::irq_ack_t    irq_ack_o
);

  localparam int unsigned IdW = `IRQ_ID_W;

  logic [`IRQ_NUM-1:0] mip_q;
  logic [`IRQ_NUM-1:0] pend_en;
  logic                win_valid;
  logic [IdW-1:0]      win_id;
  logic                ack_d;
  logic                ack_q;
  logic [IdW-1:0]      id_q;

  // --------------------------------------------------
  // Pending register
  // --------------------------------------------------
  // Lines sampled every edge, reserved ones never stored
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & `IRQ_VALID_MASK;
    end
  end

  // Locally enabled pending lines
  assign pend_en = mip_q & csr_i.mie;

  // Wake condition ignores the global enable
  assign irq_pending_o = |pend_en;

  // --------------------------------------------------
  // Priority scan
  // --------------------------------------------------
  // Order is 31..16, then 11, 3, 7
  // Lowest priority is tested first so a later hit overrides it
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en[7]) begin
      win_valid = 1'b1;
      win_id    = IdW'(7);
    end
    if (pend_en[3]) begin
      win_valid = 1'b1;
      win_id    = IdW'(3);
    end
    if (pend_en[11]) begin
      win_valid = 1'b1;
      win_id    = IdW'(11);
    end
    // Upper lines, higher index wins
    for (int i = 16; i < `IRQ_NUM; i++) begin
      if (pend_en[i]) begin
        win_valid = 1'b1;
        win_id    = IdW'(i);
      end
    end
  end

  // --------------------------------------------------
  // Acknowledge
  // --------------------------------------------------
  // Globally enabled winner, blocked for one cycle after each ack
  assign ack_d = win_valid & csr_i.mstatus_mie & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  // Id captured in the same edge as the ack it belongs to
  always_ff @(posedge clk_i) begin
    if (ack_d) begin
      id_q <= win_id;
    end
  end

  assign mip_o        = mip_q;
  assign irq_ack_o.ack = ack_q;
  assign irq_ack_o.id  = id_q;

endmodule

// File: source/irq_pkg.sv
// Struct and union types shared by the interrupt unit and its testbench
`include "irq_params.svh"

package irq_pkg;

  // --------------------------------------------------
  // CSR side
  // --------------------------------------------------
  // Enables as seen from the CSR file, valid every cycle
  typedef struct packed {
    logic [`IRQ_NUM-1:0] mie;
    logic                mstatus_mie;
  } csr_irq_t;

  // --------------------------------------------------
  // Instruction views
  // --------------------------------------------------
  // I-type layout used by SYSTEM instructions, MSB first
  typedef struct packed {
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } sys_instr_t;

  // Same word, raw or split into SYSTEM fields
  typedef union packed {
    logic [`INSTR_W-1:0] raw;
    sys_instr_t          sys;
  } instr_word_u;

  // Writeback retire strobe with bus error flag
  typedef struct packed {
    logic        valid;
    logic        err;
    instr_word_u instr;
  } wb_retire_t;

  // Acknowledge to the core, id valid only with ack
  typedef struct packed {
    logic                 ack;
    logic [`IRQ_ID_W-1:0] id;
  } irq_ack_t;

endpackage

// File: source/irq_params.svh
// Shared widths, reserved line mask and WFI encoding, included by RTL and testbench
`ifndef IRQ_PARAMS_SVH
`define IRQ_PARAMS_SVH

// --------------------------------------------------
// Interrupt lines
// --------------------------------------------------
// One line per bit of a machine word
`define IRQ_NUM 32
// Id wide enough to name any of the lines
`define IRQ_ID_W 5
// Implemented lines: 31..16 platform, 11 external, 7 timer, 3 software
`define IRQ_VALID_MASK 32'hFFFF_0888

// --------------------------------------------------
// Instruction encoding
// --------------------------------------------------
`define INSTR_W 32
// SYSTEM major opcode
`define OPC_SYSTEM 7'b111_0011
// Immediate field that selects WFI among SYSTEM words
`define FUNCT12_WFI 12'h105
// WFI has all register and funct3 fields at zero
`define RS1_ZERO 5'd0
`define FUNCT3_ZERO 3'd0
`define RD_ZERO 5'd0

`endif
